// ==== include/bridge_consts.svh ====
// bridge constants for cache line geometry and AXI field widths
`ifndef BRIDGE_CONSTS_SVH
`define BRIDGE_CONSTS_SVH

`define LINE_WIDTH      128
`define LINE_WORD_NUM   4
`define OFFSET_WIDTH    4       // byte offset within one line

`define AXI_ADDR_WIDTH  32
`define AXI_ID_WIDTH    4
`define AXI_DATA_WIDTH  32
`define AXI_STRB_WIDTH  (`AXI_DATA_WIDTH / 8)

// cache request kind for a whole line
`define REQ_TYPE_LINE   3'd4
`define AXI_SIZE_WORD   3'd2    // 4 bytes per beat

`endif

// ==== hw/axi_pkg.sv ====
// AXI side vector types shared by the bridge and its master port
`include "bridge_consts.svh"

package axi_pkg;

    typedef logic [`AXI_ADDR_WIDTH-1:0] axi_addr_t;   // byte address
    typedef logic [`AXI_DATA_WIDTH-1:0] axi_data_t;

    // bit 0 set for the data cache, clear for the instruction cache
    typedef logic [`AXI_ID_WIDTH-1:0] axi_id_t;

    typedef logic [7:0] axi_len_t;     // beats minus one
    typedef logic [2:0] axi_size_t;    // log2 bytes per beat
    typedef logic [1:0] axi_resp_t;

    typedef logic [`AXI_STRB_WIDTH-1:0] axi_strb_t;

endpackage

// ==== hw/cache_port_pkg.sv ====
// cache side types for the bridge: request kind, line payload and FSM states
`include "bridge_consts.svh"

package cache_port_pkg;

    // 0 byte, 1 half, 2 word, 4 full line
    typedef logic [2:0] req_type_t;

    typedef logic [`LINE_WIDTH-1:0] line_data_t;   // word 0 in the low bits

    typedef logic [`OFFSET_WIDTH-3:0] beat_cnt_t;

    typedef enum logic {
        rd_idle,
        rd_issue
    } rd_state_e;

    typedef enum logic [1:0] {
        wr_idle,
        wr_addr,
        wr_data,
        wr_resp
    } wr_state_e;

endpackage

// ==== hw/read_path.sv ====
// read path: cache request arbiter, AR channel issue and R beat steering
`timescale 1ns/1ps
`include "bridge_consts.svh"

module read_path (
    input  logic                      clk,
    input  logic                      reset,

    input  logic                      data_rd_req,
    input  logic                      inst_rd_req,
    input  cache_port_pkg::req_type_t data_rd_type,
    input  cache_port_pkg::req_type_t inst_rd_type,
    input  axi_pkg::axi_addr_t        data_rd_addr,
    input  axi_pkg::axi_addr_t        inst_rd_addr,
    output logic                      data_rd_rdy,
    output logic                      inst_rd_rdy,

    input  logic                      write_busy,
    input  logic                      b_done,

    output axi_pkg::axi_id_t          arid,
    output axi_pkg::axi_addr_t        araddr,
    output axi_pkg::axi_len_t         arlen,
    output axi_pkg::axi_size_t        arsize,
    output logic                      arvalid,
    input  logic                      arready,

    input  axi_pkg::axi_id_t          rid,
    input  axi_pkg::axi_data_t        rdata,
    input  logic                      rlast,
    input  logic                      rvalid,
    output logic                      rready,

    output logic                      inst_ret_valid,
    output logic                      inst_ret_last,
    output axi_pkg::axi_data_t        inst_ret_data,
    output logic                      data_ret_valid,
    output logic                      data_ret_last,
    output axi_pkg::axi_data_t        data_ret_data
);
    import axi_pkg::*;
    import cache_port_pkg::*;

    rd_state_e rd_state;
    logic      rd_open;     // idle and not held behind a write
    logic      rd_take;
    logic      sel_data;
    req_type_t sel_type;
    axi_addr_t sel_addr;
    logic      sel_line;

    // reads wait for any pending write unless its response lands now
    assign rd_open     = (rd_state == rd_idle) && !(write_busy && !b_done);
    assign data_rd_rdy = rd_open;
    assign inst_rd_rdy = rd_open && !data_rd_req;   // data side always wins
    assign rd_take     = rd_open && (data_rd_req || inst_rd_req);

    assign sel_data = data_rd_req;
    assign sel_type = sel_data ? data_rd_type : inst_rd_type;
    assign sel_addr = sel_data ? data_rd_addr : inst_rd_addr;
    assign sel_line = (sel_type == `REQ_TYPE_LINE);

    always_ff @(posedge clk) begin
        if (reset) begin
            rd_state <= rd_idle;
        end else begin
            case (rd_state)
                rd_idle: begin
                    if (rd_take) begin
                        rd_state <= rd_issue;
                    end
                end
                rd_issue: begin
                    if (arready) begin
                        rd_state <= rd_idle;
                    end
                end
                default: rd_state <= rd_idle;
            endcase
        end
    end

    // AR payload, held stable while arvalid is up
    always_ff @(posedge clk) begin
        if (rd_take) begin
            arid   <= axi_id_t'(sel_data);
            araddr <= sel_addr;
            arsize <= sel_line ? `AXI_SIZE_WORD : axi_size_t'(sel_type);
            arlen  <= sel_line ? axi_len_t'(`LINE_WORD_NUM - 1) : '0;
        end
    end

    assign arvalid = (rd_state == rd_issue);
    assign rready  = 1'b1;   // caches take every beat

    // steer by id bit 0
    assign data_ret_valid = rvalid && rid[0];
    assign data_ret_last  = rvalid && rlast && rid[0];
    assign data_ret_data  = rdata;
    assign inst_ret_valid = rvalid && !rid[0];
    assign inst_ret_last  = rvalid && rlast && !rid[0];
    assign inst_ret_data  = rdata;

endmodule

// ==== hw/write_burst.sv ====
// write engine for the data cache: AW issue, W burst from a line shift buffer, B wait
`timescale 1ns/1ps
`include "bridge_consts.svh"

module write_burst (
    input  logic                       clk,
    input  logic                       reset,

    input  logic                       data_wr_req,
    input  cache_port_pkg::req_type_t  data_wr_type,
    input  axi_pkg::axi_addr_t         data_wr_addr,
    input  axi_pkg::axi_strb_t         data_wr_wstrb,
    input  cache_port_pkg::line_data_t data_wr_data,
    output logic                       data_wr_rdy,

    output axi_pkg::axi_addr_t         awaddr,
    output axi_pkg::axi_len_t          awlen,
    output axi_pkg::axi_size_t         awsize,
    output logic                       awvalid,
    input  logic                       awready,

    output axi_pkg::axi_data_t         wdata,
    output axi_pkg::axi_strb_t         wstrb,
    output logic                       wlast,
    output logic                       wvalid,
    input  logic                       wready,

    input  logic                       bvalid,
    output logic                       bready,

    output logic                       write_busy,
    output logic                       b_done,
    output logic                       write_buffer_empty
);
    import axi_pkg::*;
    import cache_port_pkg::*;

    wr_state_e  wr_state;
    line_data_t line_buf;     // low word is the beat on the bus
    beat_cnt_t  beats_left;   // beats after the current one
    logic       wr_take;
    logic       wr_line;
    logic       w_fire;

    assign data_wr_rdy = (wr_state == wr_idle);
    assign wr_take     = data_wr_req && data_wr_rdy;
    assign wr_line     = (data_wr_type == `REQ_TYPE_LINE);
    assign w_fire      = wvalid && wready;

    assign awvalid = (wr_state == wr_addr);
    assign wvalid  = (wr_state == wr_data);
    assign bready  = (wr_state == wr_resp);
    assign wlast   = wvalid && (beats_left == '0);
    assign wdata   = line_buf[`AXI_DATA_WIDTH-1:0];

    assign write_busy         = (wr_state != wr_idle);
    assign b_done             = bvalid && bready;
    assign write_buffer_empty = (wr_state == wr_idle);

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_state <= wr_idle;
        end else begin
            case (wr_state)
                wr_idle: begin
                    if (wr_take) begin
                        wr_state <= wr_addr;
                    end
                end
                wr_addr: begin
                    if (awready) begin
                        wr_state <= wr_data;
                    end
                end
                wr_data: begin
                    if (w_fire && wlast) begin
                        wr_state <= wr_resp;
                    end
                end
                wr_resp: begin
                    if (b_done) begin
                        wr_state <= wr_idle;
                    end
                end
                default: wr_state <= wr_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            beats_left <= '0;
        end else if (wr_take) begin
            beats_left <= wr_line ? beat_cnt_t'(`LINE_WORD_NUM - 1) : '0;
        end else if (w_fire && !wlast) begin
            beats_left <= beats_left - 1'b1;
        end
    end

    // AW payload and line buffer, loaded on acceptance
    always_ff @(posedge clk) begin
        if (wr_take) begin
            awaddr   <= data_wr_addr;
            awsize   <= wr_line ? `AXI_SIZE_WORD : axi_size_t'(data_wr_type);
            awlen    <= wr_line ? axi_len_t'(`LINE_WORD_NUM - 1) : '0;
            wstrb    <= data_wr_wstrb;
            line_buf <= data_wr_data;
        end else if (w_fire) begin
            line_buf <= line_buf >> `AXI_DATA_WIDTH;   // next word down
        end
    end

endmodule

// ==== hw/cache_axi_bridge.sv ====
// cache to AXI bridge top: instruction and data cache ports onto one AXI master
`timescale 1ns/1ps

module cache_axi_bridge (
    input  logic                       clk,
    input  logic                       reset,

    // instruction cache
    input  logic                       inst_rd_req,
    input  cache_port_pkg::req_type_t  inst_rd_type,
    input  axi_pkg::axi_addr_t         inst_rd_addr,
    output logic                       inst_rd_rdy,
    output logic                       inst_ret_valid,
    output logic                       inst_ret_last,
    output axi_pkg::axi_data_t         inst_ret_data,

    // data cache
    input  logic                       data_rd_req,
    input  cache_port_pkg::req_type_t  data_rd_type,
    input  axi_pkg::axi_addr_t         data_rd_addr,
    output logic                       data_rd_rdy,
    output logic                       data_ret_valid,
    output logic                       data_ret_last,
    output axi_pkg::axi_data_t         data_ret_data,
    input  logic                       data_wr_req,
    input  cache_port_pkg::req_type_t  data_wr_type,
    input  axi_pkg::axi_addr_t         data_wr_addr,
    input  axi_pkg::axi_strb_t         data_wr_wstrb,
    input  cache_port_pkg::line_data_t data_wr_data,
    output logic                       data_wr_rdy,
    output logic                       write_buffer_empty,

    // AXI master
    output axi_pkg::axi_id_t           arid,
    output axi_pkg::axi_addr_t         araddr,
    output axi_pkg::axi_len_t          arlen,
    output axi_pkg::axi_size_t         arsize,
    output logic                       arvalid,
    input  logic                       arready,
    input  axi_pkg::axi_id_t           rid,
    input  axi_pkg::axi_data_t         rdata,
    input  logic                       rlast,
    input  logic                       rvalid,
    output logic                       rready,
    output axi_pkg::axi_addr_t         awaddr,
    output axi_pkg::axi_len_t          awlen,
    output axi_pkg::axi_size_t         awsize,
    output logic                       awvalid,
    input  logic                       awready,
    output axi_pkg::axi_data_t         wdata,
    output axi_pkg::axi_strb_t         wstrb,
    output logic                       wlast,
    output logic                       wvalid,
    input  logic                       wready,
    input  logic                       bvalid,
    output logic                       bready
);

    logic write_busy;
    logic b_done;   // write response accepted this cycle

    read_path read_path_i (
        .clk            (clk),
        .reset          (reset),
        .data_rd_req    (data_rd_req),
        .inst_rd_req    (inst_rd_req),
        .data_rd_type   (data_rd_type),
        .inst_rd_type   (inst_rd_type),
        .data_rd_addr   (data_rd_addr),
        .inst_rd_addr   (inst_rd_addr),
        .data_rd_rdy    (data_rd_rdy),
        .inst_rd_rdy    (inst_rd_rdy),
        .write_busy     (write_busy),
        .b_done         (b_done),
        .arid           (arid),
        .araddr         (araddr),
        .arlen          (arlen),
        .arsize         (arsize),
        .arvalid        (arvalid),
        .arready        (arready),
        .rid            (rid),
        .rdata          (rdata),
        .rlast          (rlast),
        .rvalid         (rvalid),
        .rready         (rready),
        .inst_ret_valid (inst_ret_valid),
        .inst_ret_last  (inst_ret_last),
        .inst_ret_data  (inst_ret_data),
        .data_ret_valid (data_ret_valid),
        .data_ret_last  (data_ret_last),
        .data_ret_data  (data_ret_data)
    );

    write_burst write_burst_i (
        .clk                (clk),
        .reset              (reset),
        .data_wr_req        (data_wr_req),
        .data_wr_type       (data_wr_type),
        .data_wr_addr       (data_wr_addr),
        .data_wr_wstrb      (data_wr_wstrb),
        .data_wr_data       (data_wr_data),
        .data_wr_rdy        (data_wr_rdy),
        .awaddr             (awaddr),
        .awlen              (awlen),
        .awsize             (awsize),
        .awvalid            (awvalid),
        .awready            (awready),
        .wdata              (wdata),
        .wstrb              (wstrb),
        .wlast              (wlast),
        .wvalid             (wvalid),
        .wready             (wready),
        .bvalid             (bvalid),
        .bready             (bready),
        .write_busy         (write_busy),
        .b_done             (b_done),
        .write_buffer_empty (write_buffer_empty)
    );

endmodule

// ==== sim/axi_mem_model.sv ====
// behavioral AXI slave memory of 256 words with random ready and response stalls
`timescale 1ns/1ps

module axi_mem_model (
    input  logic               clk,
    input  logic               reset,
    input  axi_pkg::axi_id_t   arid,
    input  axi_pkg::axi_addr_t araddr,
    input  axi_pkg::axi_len_t  arlen,
    input  logic               arvalid,
    output logic               arready,
    output axi_pkg::axi_id_t   rid,
    output axi_pkg::axi_data_t rdata,
    output logic               rlast,
    output logic               rvalid,
    input  logic               rready,
    input  axi_pkg::axi_addr_t awaddr,
    input  logic               awvalid,
    output logic               awready,
    input  axi_pkg::axi_data_t wdata,
    input  axi_pkg::axi_strb_t wstrb,
    input  logic               wlast,
    input  logic               wvalid,
    output logic               wready,
    output logic               bvalid,
    input  logic               bready
);
    import axi_pkg::*;

    logic [31:0] mem [0:255];   // word index is addr[9:2]
    logic [31:0] rng;
    logic        rd_busy;
    logic        b_pend;
    axi_id_t     rd_id;
    logic [7:0]  rd_idx;
    logic [7:0]  wr_idx;
    axi_len_t    rd_left;       // beats after the current one
    logic [1:0]  rd_wait;
    logic [1:0]  b_wait;

    // handshakes due at the coming edge, with their payloads
    logic        ar_hs, r_hs, aw_hs, w_hs, b_hs;
    axi_id_t     ar_id;
    axi_addr_t   ar_addr;
    axi_addr_t   aw_addr;
    axi_len_t    ar_len;
    axi_data_t   w_data;
    axi_strb_t   w_strb;
    logic        w_last;

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        return y ^ (y << 5);
    endfunction

    function automatic logic [31:0] fill_word(input logic [7:0] idx);
        return {idx, ~idx, idx ^ 8'h5a, 8'hc3};
    endfunction

    initial begin
        int i;
        int k;
        rng     = 32'd60;
        arready = 1'b0;
        awready = 1'b0;
        wready  = 1'b0;
        rvalid  = 1'b0;
        rlast   = 1'b0;
        rid     = '0;
        rdata   = '0;
        bvalid  = 1'b0;
        rd_busy = 1'b0;
        b_pend  = 1'b0;
        forever begin
            @(negedge clk);
            ar_hs   = arvalid && arready;
            r_hs    = rvalid && rready;
            aw_hs   = awvalid && awready;
            w_hs    = wvalid && wready;
            b_hs    = bvalid && bready;
            ar_id   = arid;
            ar_addr = araddr;
            ar_len  = arlen;
            aw_addr = awaddr;
            w_data  = wdata;
            w_strb  = wstrb;
            w_last  = wlast;
            @(posedge clk);
            #1;
            if (reset) begin
                for (i = 0; i < 256; i++) begin
                    mem[i] = fill_word(8'(i));
                end
                {arready, awready, wready, rvalid, rlast, bvalid} = '0;
                rd_busy = 1'b0;
                b_pend  = 1'b0;
            end else begin
                rng = xorshift32(rng);
                if (r_hs) begin
                    if (rlast) begin
                        rvalid  = 1'b0;
                        rd_busy = 1'b0;
                    end else begin
                        rd_idx  = rd_idx + 8'd1;   // INCR burst
                        rd_left = rd_left - 8'd1;
                    end
                end
                if (ar_hs) begin
                    rd_busy = 1'b1;
                    rd_id   = ar_id;
                    rd_idx  = ar_addr[9:2];
                    rd_left = ar_len;
                    rd_wait = rng[7:6];
                end
                if (rd_busy) begin
                    if (rd_wait != 2'd0) begin
                        rd_wait = rd_wait - 2'd1;   // delayed first beat
                    end else begin
                        rvalid = 1'b1;
                        rid    = rd_id;
                        rdata  = mem[rd_idx];
                        rlast  = (rd_left == 8'd0);
                    end
                end

                if (aw_hs) begin
                    wr_idx = aw_addr[9:2];
                end
                if (w_hs) begin
                    for (k = 0; k < 4; k++) begin
                        if (w_strb[k]) begin
                            mem[wr_idx][8*k +: 8] = w_data[8*k +: 8];
                        end
                    end
                    wr_idx = wr_idx + 8'd1;
                    if (w_last) begin
                        b_pend = 1'b1;
                        b_wait = rng[9:8];
                    end
                end
                if (b_hs) begin
                    bvalid = 1'b0;
                end
                if (b_pend) begin
                    if (b_wait != 2'd0) begin
                        b_wait = b_wait - 2'd1;
                    end else begin
                        bvalid = 1'b1;
                        b_pend = 1'b0;
                    end
                end

                arready = !rd_busy && (rng[1:0] != 2'd0);   // one read at a time
                awready = (rng[3:2] != 2'd0);
                wready  = (rng[5:4] != 2'd0);
            end
        end
    end

endmodule

// ==== sim/tb_cache_axi_bridge.sv ====
// testbench for the cache to AXI bridge with directed and random cache traffic on a memory model
`timescale 1ns/1ps
`include "bridge_consts.svh"

module tb_cache_axi_bridge;
    import axi_pkg::*;
    import cache_port_pkg::*;

    localparam int MAX_CYCLES = 4000;   // 6 tests x 40 ops x about 16 cycles

    logic       clk;
    logic       reset;
    logic       inst_rd_req, data_rd_req, data_wr_req;
    req_type_t  inst_rd_type, data_rd_type, data_wr_type;
    axi_addr_t  inst_rd_addr, data_rd_addr, data_wr_addr;
    axi_strb_t  data_wr_wstrb;
    line_data_t data_wr_data;
    logic       inst_rd_rdy, data_rd_rdy, data_wr_rdy, write_buffer_empty;
    logic       inst_ret_valid, inst_ret_last, data_ret_valid, data_ret_last;
    axi_data_t  inst_ret_data, data_ret_data, rdata, wdata;
    axi_id_t    arid, rid;
    axi_addr_t  araddr, awaddr;
    axi_len_t   arlen, awlen;
    axi_size_t  arsize, awsize;
    axi_strb_t  wstrb;
    logic       arvalid, arready, rlast, rvalid, rready, awvalid, awready;
    logic       wlast, wvalid, wready, bvalid, bready;

    logic [31:0] mirror [0:255];
    logic [32:0] exp_data_q[$];   // {last, word}
    logic [32:0] exp_inst_q[$];
    logic [10:0] exp_ard_q[$];    // {len, size} per data read
    logic [10:0] exp_ari_q[$];
    logic [10:0] exp_aw_q[$];
    int          data_seen = 0;    // beats checked so far
    int          inst_seen = 0;
    int          ard_seen = 0;
    int          ari_seen = 0;
    int          aw_seen = 0;
    int          wr_started = 0;
    int          b_seen = 0;
    int          seq_errors = 0;
    int          mon_errors = 0;
    int          cycles = 0;
    int          last_data_acc, last_inst_acc;
    int          tests_run = 0;
    int          tests_failed = 0;
    int          err_base;
    string       cur_test = "reset";
    logic [31:0] rng = 32'd60;

    cache_axi_bridge dut_i (.*);
    axi_mem_model mem_i (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("timeout: %s still waiting on beats or a write response after %0d cycles",
                     cur_test, cycles);
            $display("Test failed");
            $finish;
        end
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        return y ^ (y << 5);
    endfunction

    function automatic logic [31:0] fill_word(input logic [7:0] idx);
        return {idx, ~idx, idx ^ 8'h5a, 8'hc3};
    endfunction

    function automatic line_data_t random_line();
        line_data_t line;
        int k;
        for (k = 0; k < `LINE_WORD_NUM; k++) begin
            rng = xorshift32(rng);
            line[32*k +: 32] = rng;
        end
        return line;
    endfunction

    task automatic check_beat(input string port, input bit expected, input logic [32:0] exp,
                              input axi_data_t got, input logic last);
        assert (expected) else begin
            $display("unexpected beat on the %s return port during %s", port, cur_test);
            mon_errors++;
        end
        if (expected) begin
            assert (got == exp[31:0]) else begin
                $display("mismatch %s: %s data expected %h actual %h",
                         cur_test, port, exp[31:0], got);
                mon_errors++;
            end
            assert (last == exp[32]) else begin
                $display("mismatch %s: %s last expected %b actual %b", cur_test, port, exp[32], last);
                mon_errors++;
            end
        end
    endtask

    task automatic compare_burst(input string chan, input bit expected, input logic [10:0] exp,
                                 input axi_len_t len, input axi_size_t size);
        assert (expected) else begin
            $display("%s handshake with no matching request during %s", chan, cur_test);
            mon_errors++;
        end
        if (expected) begin
            assert (len == exp[10:3]) else begin
                $display("mismatch %s: %s len expected %0d actual %0d",
                         cur_test, chan, exp[10:3], len);
                mon_errors++;
            end
            assert (size == exp[2:0]) else begin
                $display("mismatch %s: %s size expected %0d actual %0d",
                         cur_test, chan, exp[2:0], size);
                mon_errors++;
            end
        end
    endtask

    // sampled mid-cycle once every output has settled
    always @(negedge clk) begin
        if (!reset) begin
            if (data_ret_valid) begin
                check_beat("data", data_seen < exp_data_q.size(),
                           (data_seen < exp_data_q.size()) ? exp_data_q[data_seen] : '0,
                           data_ret_data, data_ret_last);
                data_seen++;
            end
            if (inst_ret_valid) begin
                check_beat("inst", inst_seen < exp_inst_q.size(),
                           (inst_seen < exp_inst_q.size()) ? exp_inst_q[inst_seen] : '0,
                           inst_ret_data, inst_ret_last);
                inst_seen++;
            end
            if (arvalid && arready) begin
                if (arid[0]) begin
                    compare_burst("ar data", ard_seen < exp_ard_q.size(),
                                  (ard_seen < exp_ard_q.size()) ? exp_ard_q[ard_seen] : '0,
                                  arlen, arsize);
                    ard_seen++;
                end else begin
                    compare_burst("ar inst", ari_seen < exp_ari_q.size(),
                                  (ari_seen < exp_ari_q.size()) ? exp_ari_q[ari_seen] : '0,
                                  arlen, arsize);
                    ari_seen++;
                end
            end
            if (awvalid && awready) begin
                compare_burst("aw", aw_seen < exp_aw_q.size(),
                              (aw_seen < exp_aw_q.size()) ? exp_aw_q[aw_seen] : '0,
                              awlen, awsize);
                aw_seen++;
            end
            assert (!(data_rd_req && inst_rd_rdy)) else begin
                $display("inst_rd_rdy high while data_rd_req is high during %s", cur_test);
                mon_errors++;
            end
            if (wr_started != b_seen) begin
                assert (!write_buffer_empty && !data_wr_rdy) else begin
                    $display("write status shows idle while a write is pending in %s", cur_test);
                    mon_errors++;
                end
                assert ((bvalid && bready) || !data_rd_rdy) else begin
                    $display("data read accepted ahead of a pending write in %s", cur_test);
                    mon_errors++;
                end
                if (bvalid && bready) begin
                    b_seen++;
                end
            end else begin
                assert (write_buffer_empty && data_wr_rdy) else begin
                    $display("write status shows busy with no write pending in %s", cur_test);
                    mon_errors++;
                end
            end
        end
    end

    task automatic issue_read(input logic is_data, input req_type_t kind, input axi_addr_t addr);
        int n;
        int k;
        logic [7:0] idx;
        logic [10:0] burst;
        n     = (kind == `REQ_TYPE_LINE) ? `LINE_WORD_NUM : 1;
        idx   = addr[9:2];
        burst = (kind == `REQ_TYPE_LINE) ? {8'(`LINE_WORD_NUM - 1), 3'd2} : {8'd0, kind};
        for (k = 0; k < n; k++) begin
            if (is_data) begin
                exp_data_q.push_back({k == n - 1, mirror[idx]});
            end else begin
                exp_inst_q.push_back({k == n - 1, mirror[idx]});
            end
            idx = idx + 8'd1;
        end
        if (is_data) begin
            exp_ard_q.push_back(burst);
            data_rd_req  = 1'b1;
            data_rd_type = kind;
            data_rd_addr = addr;
        end else begin
            exp_ari_q.push_back(burst);
            inst_rd_req  = 1'b1;
            inst_rd_type = kind;
            inst_rd_addr = addr;
        end
        do @(negedge clk); while (!(is_data ? data_rd_rdy : inst_rd_rdy));
        @(posedge clk);
        #1;
        if (is_data) begin
            data_rd_req   = 1'b0;
            last_data_acc = cycles;
        end else begin
            inst_rd_req   = 1'b0;
            last_inst_acc = cycles;
        end
    endtask

    task automatic issue_write(input req_type_t kind, input axi_addr_t addr,
                               input axi_strb_t strb, input line_data_t data);
        int k;
        logic [7:0] idx;
        logic [10:0] burst;
        // reads still in flight must not see this data
        while (data_seen != exp_data_q.size() || inst_seen != exp_inst_q.size()) @(negedge clk);
        @(posedge clk);
        #1;
        burst = (kind == `REQ_TYPE_LINE) ? {8'(`LINE_WORD_NUM - 1), 3'd2} : {8'd0, kind};
        exp_aw_q.push_back(burst);
        data_wr_req   = 1'b1;
        data_wr_type  = kind;
        data_wr_addr  = addr;
        data_wr_wstrb = strb;
        data_wr_data  = data;
        do @(negedge clk); while (!data_wr_rdy);
        @(posedge clk);
        #1;
        data_wr_req = 1'b0;
        wr_started++;
        idx = addr[9:2];
        for (k = 0; k < `LINE_WORD_NUM; k++) begin
            if (kind == `REQ_TYPE_LINE) begin
                mirror[idx] = data[32*k +: 32];
                idx = idx + 8'd1;
            end else if (strb[k]) begin
                mirror[idx][8*k +: 8] = data[8*k +: 8];   // enabled bytes only
            end
        end
    endtask

    task automatic start_test(input string name);
        cur_test = name;
        err_base = seq_errors + mon_errors;
    endtask

    task automatic finish_test();
        int errs;
        while (data_seen != exp_data_q.size() || inst_seen != exp_inst_q.size()
               || wr_started != b_seen) @(negedge clk);
        @(posedge clk);
        #1;
        errs = seq_errors + mon_errors - err_base;
        tests_run++;
        if (errs != 0) begin
            tests_failed++;
        end
        $display("%-14s %s, %0d errors", cur_test, (errs == 0) ? "pass" : "FAIL", errs);
    endtask

    initial begin
        int i;
        reset = 1'b1;
        {inst_rd_req, data_rd_req, data_wr_req} = '0;
        {inst_rd_type, data_rd_type, data_wr_type} = '0;
        {inst_rd_addr, data_rd_addr, data_wr_addr} = '0;
        data_wr_wstrb = '0;
        data_wr_data  = '0;
        for (i = 0; i < 256; i++) begin
            mirror[i] = fill_word(8'(i));
        end
        repeat (10) @(posedge clk);
        #1;
        reset = 1'b0;
        @(negedge clk);
        assert (data_rd_rdy && inst_rd_rdy && rready && !arvalid && !awvalid && !wvalid
                && !wlast && !bready) else begin
            $display("bridge outputs not at their reset values");
            seq_errors++;
        end
        @(posedge clk);
        #1;

        start_test("word_read");
        issue_read(1'b1, 3'd2, 32'h0000_0010);
        finish_test();

        start_test("inst_line");
        issue_read(1'b0, `REQ_TYPE_LINE, 32'h0000_0040);
        finish_test();

        start_test("arbitration");
        fork
            issue_read(1'b1, 3'd2, 32'h0000_0100);
            issue_read(1'b0, `REQ_TYPE_LINE, 32'h0000_0200);
        join
        assert (last_data_acc < last_inst_acc) else begin
            $display("instruction read accepted before the data read");
            seq_errors++;
        end
        finish_test();

        start_test("write_merge");
        issue_write(`REQ_TYPE_LINE, 32'h0000_0060, 4'hf, random_line());
        issue_read(1'b1, `REQ_TYPE_LINE, 32'h0000_0060);
        issue_write(3'd2, 32'h0000_0068, 4'b0101, random_line());
        issue_read(1'b1, 3'd2, 32'h0000_0068);
        finish_test();

        start_test("write_status");
        issue_write(`REQ_TYPE_LINE, 32'h0000_0080, 4'hf, random_line());
        issue_read(1'b1, 3'd2, 32'h0000_0084);   // held off until B
        finish_test();

        start_test("random");
        for (i = 0; i < 40; i++) begin
            rng = xorshift32(rng);
            case (rng[1:0])
                2'd0: issue_read(1'b1, 3'd2, {22'd0, rng[9:2], 2'd0});
                2'd1: issue_read(rng[10], `REQ_TYPE_LINE, {22'd0, rng[9:4], 4'd0});
                2'd2: issue_write(`REQ_TYPE_LINE, {22'd0, rng[9:4], 4'd0}, 4'hf, random_line());
                default: issue_write(3'd2, {22'd0, rng[9:2], 2'd0}, rng[14:11], random_line());
            endcase
        end
        finish_test();

        $display("tests run %0d, failed %0d, errors %0d",
                 tests_run, tests_failed, seq_errors + mon_errors);
        if (tests_failed == 0 && seq_errors + mon_errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// ==== filelist.f ====
+incdir+include
hw/axi_pkg.sv
hw/cache_port_pkg.sv
hw/read_path.sv
hw/write_burst.sv
hw/cache_axi_bridge.sv
sim/axi_mem_model.sv
sim/tb_cache_axi_bridge.sv

// ==== run_sim.sh ====
#!/bin/sh
# build the bridge testbench with Verilator, run it and scan the log
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module tb_cache_axi_bridge -f filelist.f \
    --Mdir obj_dir -o sim_bridge

./obj_dir/sim_bridge > sim.log
cat sim.log

if grep -q "Test failed" sim.log; then
    echo "simulation reported a failure"
    exit 1
fi
